/* design/mbus_ctrl.sv */
// 68000 main-bus FSM: address decode, device sequencing,
// ROM handshake, Z80 window forwarding and Z80 control registers

module mbus_ctrl import md_bus_pkg::*; #(
	parameter int WRAM_AW = 15,
	parameter int SRAM_AW = 16
) (
	input  logic               MCLK,
	input  logic               reset,
	input  m68k_req_t          m68k_req,
	output logic [MBUS_DW-1:0] m68k_rdata,
	output logic               m68k_dtack,
	input  logic [ROM_AW-1:0]  rom_size,
	output logic               rom_req,
	input  logic               rom_ack,
	input  logic [MBUS_DW-1:0] rom_data,
	output logic [1:0]         rom_be,
	output logic [MBUS_DW-1:0] rom_wdata,
	output logic [MBUS_AW-1:0] mbus_addr,
	output logic [WRAM_AW-1:0] wram_addr,
	output logic [1:0]         wram_we,
	input  logic [MBUS_DW-1:0] wram_q,
	output logic [SRAM_AW-1:0] sram_addr,
	output logic               sram_we,
	input  logic [7:0]         sram_q,
	output logic [MBUS_DW-1:0] wdata,
	input  logic               bank_sram,
	output logic               bank_we,
	output zbus_req_t          zbus_req,
	input  logic               mbus_zack,
	input  logic [ZBUS_DW-1:0] mbus_zdata,
	input  logic               z80_busak_n,
	output logic               z80_busreq_n,
	output logic               z80_reset_n
);

	mbus_state_e        state;
	mbus_region_e       region;
	logic               mbus_rnw;
	logic               mbus_uds_n;
	logic               mbus_lds_n;
	logic [MBUS_DW-1:0] rd_data;
	logic [3:0]         ctrl_idx;

	assign ctrl_idx  = mbus_addr[10:7];
	assign rom_be    = ~{mbus_uds_n, mbus_lds_n};
	assign rom_wdata = wdata;
	assign wram_addr = mbus_addr[WRAM_AW-1:0];
	assign sram_addr = mbus_addr[SRAM_AW-1:0];

	// RAM writes happen in the read state, address is stable since capture
	assign wram_we = (state == MBUS_RAM_READ && !mbus_rnw) ? rom_be : 2'b00;
	assign sram_we = (state == MBUS_SRAM_READ) && !mbus_rnw;

	//------------------------------------------------------------
	// Address decode on the captured word address
	//------------------------------------------------------------
	always_comb begin
		region = RGN_NONE;
		if (mbus_addr[22:19] < 4'hA) begin
			// Mapper SRAM enable overrides ROM at 200000-3FFFFF
			if (bank_sram && mbus_addr[22:20] == 3'b001) begin
				region = RGN_SRAM;
			end else if ({1'b0, mbus_addr} < rom_size) begin
				region = RGN_ROM;
			end else if (mbus_addr[22:20] == 3'b001 && !(&mbus_addr[19:18])) begin
				region = RGN_SRAM;
			end
		end else if (mbus_addr[22:15] == 8'hA0) begin
			region = RGN_ZBUS;
		end else if (mbus_addr[22:11] == 12'hA11 && mbus_addr[6:0] == '0
			&& (ctrl_idx == 4'd1 || ctrl_idx == 4'd2)) begin
			region = RGN_CTRL;
		end else if (mbus_addr[22:7] == 16'hA130) begin
			region = RGN_MAPPER;
		end else if (&mbus_addr[22:20]) begin
			region = RGN_WRAM;
		end
	end

	//------------------------------------------------------------
	// Access sequencing
	//------------------------------------------------------------
	always_ff @(posedge MCLK) begin
		bank_we <= 1'b0;
		if (reset) begin
			state        <= MBUS_IDLE;
			m68k_dtack   <= 1'b0;
			rom_req      <= 1'b0;
			zbus_req.sel <= 1'b0;
			z80_busreq_n <= 1'b1;
			z80_reset_n  <= 1'b0;
		end else begin
			// dtack drops the cycle after as goes away
			if (!m68k_req.as) m68k_dtack <= 1'b0;

			case (state)
				MBUS_IDLE: begin
					if (m68k_req.as && !m68k_dtack) begin
						mbus_addr  <= m68k_req.addr;
						mbus_rnw   <= m68k_req.rnw;
						mbus_uds_n <= m68k_req.uds_n;
						mbus_lds_n <= m68k_req.lds_n;
						wdata      <= m68k_req.wdata;
						rd_data    <= '0;
						state      <= MBUS_SELECT;
					end
				end

				MBUS_SELECT: begin
					state <= MBUS_FINISH;
					case (region)
						RGN_ROM: begin
							if (mbus_rnw) begin
								rom_req <= ~rom_ack;
								state   <= MBUS_ROM_READ;
							end
						end
						RGN_SRAM: state <= MBUS_SRAM_READ;
						RGN_WRAM: state <= MBUS_RAM_READ;
						RGN_ZBUS: begin
							// Window is closed unless the Z80 bus is requested
							if (!z80_busreq_n) begin
								zbus_req.sel   <= 1'b1;
								zbus_req.we    <= ~mbus_rnw;
								zbus_req.addr  <= {mbus_addr[ZBUS_AW-2:0], mbus_uds_n};
								zbus_req.wdata <= mbus_uds_n ? wdata[7:0] : wdata[15:8];
								state          <= MBUS_ZBUS_WAIT;
							end
						end
						RGN_CTRL: begin
							if (!mbus_rnw && !mbus_uds_n) begin
								if (ctrl_idx == 4'd1) z80_busreq_n <= ~wdata[8];
								if (ctrl_idx == 4'd2) z80_reset_n <= wdata[8];
							end
							rd_data[8] <= (ctrl_idx == 4'd1) ? z80_busak_n : z80_reset_n;
						end
						RGN_MAPPER: bank_we <= ~mbus_rnw;
						default: ;
					endcase
				end

				MBUS_ROM_READ: begin
					if (rom_req == rom_ack) begin
						rd_data <= rom_data;
						state   <= MBUS_FINISH;
					end
				end

				MBUS_RAM_READ: begin
					rd_data <= wram_q;
					state   <= MBUS_FINISH;
				end

				MBUS_SRAM_READ: begin
					rd_data <= {sram_q, sram_q};
					state   <= MBUS_FINISH;
				end

				MBUS_ZBUS_WAIT: begin
					if (mbus_zack) begin
						zbus_req.sel <= 1'b0;
						rd_data      <= {mbus_zdata, mbus_zdata};
						state        <= MBUS_FINISH;
					end
				end

				MBUS_FINISH: begin
					m68k_rdata <= rd_data;
					m68k_dtack <= 1'b1;
					state      <= MBUS_IDLE;
				end

				default: state <= MBUS_IDLE;
			endcase
		end
	end

endmodule

/* design/md_bus_pkg.sv */
// Shared bus widths, request structs and state encodings
// for the 68000 main bus and the Z80 bus controller

package md_bus_pkg;

	// Bus widths
	localparam int MBUS_AW    = 23;
	localparam int MBUS_DW    = 16;
	localparam int ROM_AW     = 24;
	localparam int ZBUS_AW    = 15;
	localparam int ZBUS_DW    = 8;
	localparam int BANK_COUNT = 8;
	localparam int BANK_W     = 5;

	// 68000 master, word address plus lane strobes
	typedef struct packed {
		logic               as;
		logic               rnw;
		logic               uds_n;
		logic               lds_n;
		logic [MBUS_AW-1:0] addr;
		logic [MBUS_DW-1:0] wdata;
	} m68k_req_t;

	// Z80 master, byte address
	typedef struct packed {
		logic        sel;
		logic        wr;
		logic [15:0] addr;
		logic [7:0]  wdata;
	} z80_req_t;

	// 68000 access forwarded into the Z80 bus
	typedef struct packed {
		logic               sel;
		logic               we;
		logic [ZBUS_AW-1:0] addr;
		logic [ZBUS_DW-1:0] wdata;
	} zbus_req_t;

	typedef enum logic [2:0] {
		MBUS_IDLE, MBUS_SELECT, MBUS_RAM_READ, MBUS_ROM_READ,
		MBUS_SRAM_READ, MBUS_ZBUS_WAIT, MBUS_FINISH
	} mbus_state_e;

	typedef enum logic [2:0] {
		RGN_ROM, RGN_SRAM, RGN_WRAM, RGN_ZBUS, RGN_CTRL, RGN_MAPPER, RGN_NONE
	} mbus_region_e;

	typedef enum logic [1:0] {ZBUS_IDLE, ZBUS_ACCESS, ZBUS_FINISH} zbus_state_e;

	typedef enum logic {ZSRC_MBUS, ZSRC_Z80} zbus_src_e;

endpackage

/* design/md_bus_top.sv */
// Bus controller top: main-bus FSM, ROM mapper, Z80 bus arbiter
// and the work RAM, save RAM and Z80 RAM instances

module md_bus_top import md_bus_pkg::*; #(
	parameter int WRAM_AW = 15,
	parameter int SRAM_AW = 16,
	parameter int ZRAM_AW = 13
) (
	input  logic               MCLK,
	input  logic               reset,
	input  m68k_req_t          m68k_req,
	output logic [MBUS_DW-1:0] m68k_rdata,
	output logic               m68k_dtack,
	input  z80_req_t           z80_req,
	output logic [7:0]         z80_rdata,
	output logic               z80_ack,
	input  logic [ROM_AW-1:0]  rom_size,
	output logic [ROM_AW-1:0]  rom_addr,
	output logic [MBUS_DW-1:0] rom_wdata,
	output logic [1:0]         rom_be,
	output logic               rom_req,
	input  logic               rom_ack,
	input  logic [MBUS_DW-1:0] rom_data,
	input  logic               z80_busak_n,
	output logic               z80_busreq_n,
	output logic               z80_reset_n
);

	logic [MBUS_AW-1:0] mbus_addr;
	logic [MBUS_DW-1:0] wdata;
	logic [WRAM_AW-1:0] wram_addr;
	logic [1:0]         wram_we;
	logic [MBUS_DW-1:0] wram_q;
	logic [SRAM_AW-1:0] sram_addr;
	logic               sram_we;
	logic [7:0]         sram_q;
	logic               bank_sram;
	logic               bank_we;
	zbus_req_t          zbus_req;
	logic               mbus_zack;
	logic [ZBUS_DW-1:0] mbus_zdata;
	logic [ZRAM_AW-1:0] zram_addr;
	logic               zram_we;
	logic [ZBUS_DW-1:0] zram_wdata;
	logic [ZBUS_DW-1:0] zram_q;

	mbus_ctrl #(.WRAM_AW(WRAM_AW), .SRAM_AW(SRAM_AW)) u_mbus_ctrl (
		.MCLK(MCLK), .reset(reset),
		.m68k_req(m68k_req), .m68k_rdata(m68k_rdata), .m68k_dtack(m68k_dtack),
		.rom_size(rom_size), .rom_req(rom_req), .rom_ack(rom_ack),
		.rom_data(rom_data), .rom_be(rom_be), .rom_wdata(rom_wdata),
		.mbus_addr(mbus_addr),
		.wram_addr(wram_addr), .wram_we(wram_we), .wram_q(wram_q),
		.sram_addr(sram_addr), .sram_we(sram_we), .sram_q(sram_q),
		.wdata(wdata), .bank_sram(bank_sram), .bank_we(bank_we),
		.zbus_req(zbus_req), .mbus_zack(mbus_zack), .mbus_zdata(mbus_zdata),
		.z80_busak_n(z80_busak_n), .z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n)
	);

	rom_bank_regs u_rom_bank_regs (
		.MCLK(MCLK), .reset(reset), .bank_we(bank_we),
		.mbus_addr(mbus_addr), .wdata(wdata), .rom_size(rom_size),
		.rom_addr(rom_addr), .bank_sram(bank_sram)
	);

	zbus_ctrl #(.ZRAM_AW(ZRAM_AW)) u_zbus_ctrl (
		.MCLK(MCLK), .reset(reset),
		.zbus_req(zbus_req), .z80_busreq_n(z80_busreq_n), .z80_reset_n(z80_reset_n),
		.mbus_zack(mbus_zack), .mbus_zdata(mbus_zdata),
		.z80_req(z80_req), .z80_rdata(z80_rdata), .z80_ack(z80_ack),
		.zram_addr(zram_addr), .zram_we(zram_we), .zram_wdata(zram_wdata),
		.zram_q(zram_q)
	);

	// 68000 work RAM, upper and lower byte lanes
	ram_sp #(.DEPTH_AW(WRAM_AW), .LANES(2)) u_wram (
		.MCLK(MCLK), .addr(wram_addr), .we(wram_we), .wdata(wdata), .q(wram_q)
	);

	ram_sp #(.DEPTH_AW(SRAM_AW), .LANES(1)) u_sram (
		.MCLK(MCLK), .addr(sram_addr), .we(sram_we), .wdata(wdata[7:0]), .q(sram_q)
	);

	ram_sp #(.DEPTH_AW(ZRAM_AW), .LANES(1)) u_zram (
		.MCLK(MCLK), .addr(zram_addr), .we(zram_we), .wdata(zram_wdata), .q(zram_q)
	);

endmodule

/* design/ram_sp.sv */
// Single-port synchronous RAM with byte-lane writes

module ram_sp #(
	parameter int DEPTH_AW = 13,
	parameter int LANES    = 1
) (
	input  logic                  MCLK,
	input  logic [DEPTH_AW-1:0]   addr,
	input  logic [LANES-1:0]      we,
	input  logic [8*LANES-1:0]    wdata,
	output logic [8*LANES-1:0]    q
);

	logic [LANES-1:0][7:0] mem [2**DEPTH_AW];

	// Lane writes, read of the old contents one cycle later
	always_ff @(posedge MCLK) begin
		for (int i = 0; i < LANES; i++) begin
			if (we[i]) begin
				mem[addr][i] <= wdata[8*i +: 8];
			end
		end
		q <= mem[addr];
	end

endmodule

/* design/rom_bank_regs.sv */
// ROM mapper bank registers, save-RAM enable and
// translation of the main-bus address into a ROM word address

module rom_bank_regs import md_bus_pkg::*; (
	input  logic               MCLK,
	input  logic               reset,
	input  logic               bank_we,
	input  logic [MBUS_AW-1:0] mbus_addr,
	input  logic [MBUS_DW-1:0] wdata,
	input  logic [ROM_AW-1:0]  rom_size,
	output logic [ROM_AW-1:0]  rom_addr,
	output logic               bank_sram
);

	localparam int IDX_W = $clog2(BANK_COUNT);
	// 512 KB windows, counted in words
	localparam int OFS_W = 18;
	localparam logic [ROM_AW-1:0] ROM_2MB = ROM_AW'(24'h100000);

	logic [BANK_W-1:0] bank_reg [BANK_COUNT];
	logic              bank_rom;
	logic [IDX_W-1:0]  wr_idx;
	logic [IDX_W-1:0]  rd_idx;

	assign wr_idx = mbus_addr[IDX_W-1:0];
	assign rd_idx = mbus_addr[OFS_W +: IDX_W];

	always_ff @(posedge MCLK) begin
		if (reset) begin
			for (int i = 0; i < BANK_COUNT; i++) begin
				bank_reg[i] <= BANK_W'(i);
			end
			bank_rom  <= 1'b0;
			bank_sram <= 1'b0;
		end else if (bank_we) begin
			if (rom_size > ROM_2MB) begin
				if (wr_idx != '0) begin
					bank_reg[wr_idx] <= wdata[BANK_W-1:0];
					bank_rom         <= 1'b1;
				end else begin
					bank_sram <= wdata[0];
				end
			end else begin
				// Small carts only have the SRAM enable
				bank_sram <= wdata[0];
			end
		end
	end

	assign rom_addr = bank_rom ? ROM_AW'({bank_reg[rd_idx], mbus_addr[OFS_W-1:0]})
		: ROM_AW'(mbus_addr);

endmodule

/* design/zbus_ctrl.sv */
// Z80 bus arbiter between the 68000 window and the Z80 port,
// with Z80 RAM decode and 68000-side access gating

module zbus_ctrl import md_bus_pkg::*; #(
	parameter int ZRAM_AW = 13
) (
	input  logic               MCLK,
	input  logic               reset,
	input  zbus_req_t          zbus_req,
	input  logic               z80_busreq_n,
	input  logic               z80_reset_n,
	output logic               mbus_zack,
	output logic [ZBUS_DW-1:0] mbus_zdata,
	input  z80_req_t           z80_req,
	output logic [7:0]         z80_rdata,
	output logic               z80_ack,
	output logic [ZRAM_AW-1:0] zram_addr,
	output logic               zram_we,
	output logic [ZBUS_DW-1:0] zram_wdata,
	input  logic [ZBUS_DW-1:0] zram_q
);

	zbus_state_e        state;
	zbus_src_e          src;
	logic [ZBUS_AW-1:0] zaddr;
	logic               zhit;
	logic               zbus_free;
	logic [ZBUS_DW-1:0] zdata;

	// 68000 owns the window only with the Z80 held off and running
	assign zbus_free = ~z80_busreq_n & z80_reset_n;
	assign zram_addr = zaddr[ZRAM_AW-1:0];
	assign zdata     = zhit ? zram_q : 8'hFF;

	always_ff @(posedge MCLK) begin
		zram_we <= 1'b0;
		if (reset) begin
			state     <= ZBUS_IDLE;
			mbus_zack <= 1'b0;
			z80_ack   <= 1'b0;
		end else begin
			if (!zbus_req.sel) mbus_zack <= 1'b0;
			if (!z80_req.sel) z80_ack <= 1'b0;

			case (state)
				ZBUS_IDLE: begin
					// Main-bus side wins a tie
					if (zbus_req.sel && !mbus_zack) begin
						zaddr      <= zbus_req.addr;
						zram_wdata <= zbus_req.wdata;
						zhit       <= ~zbus_req.addr[14];
						zram_we    <= zbus_req.we & zbus_free & ~zbus_req.addr[14];
						src        <= ZSRC_MBUS;
						state      <= ZBUS_ACCESS;
					end else if (z80_req.sel && !z80_ack) begin
						zaddr      <= z80_req.addr[ZBUS_AW-1:0];
						zram_wdata <= z80_req.wdata;
						zhit       <= (z80_req.addr[15:14] == 2'b00);
						zram_we    <= z80_req.wr & (z80_req.addr[15:14] == 2'b00);
						src        <= ZSRC_Z80;
						state      <= ZBUS_ACCESS;
					end
				end

				ZBUS_ACCESS: state <= ZBUS_FINISH;

				ZBUS_FINISH: begin
					if (src == ZSRC_MBUS) begin
						mbus_zdata <= zbus_free ? zdata : 8'hFF;
						mbus_zack  <= 1'b1;
					end else begin
						z80_rdata <= zdata;
						z80_ack   <= 1'b1;
					end
					state <= ZBUS_IDLE;
				end

				default: state <= ZBUS_IDLE;
			endcase
		end
	end

endmodule

/* flist.f */
design/md_bus_pkg.sv
design/ram_sp.sv
design/rom_bank_regs.sv
design/zbus_ctrl.sv
design/mbus_ctrl.sv
design/md_bus_top.sv
verification/md_bus_checker.sv
verification/tb_md_bus.sv

/* run.sh */
#!/usr/bin/env bash
# Build the bus controller testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_md_bus -f flist.f -o tb_md_bus \
	> build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_md_bus > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1

/* verification/md_bus_checker.sv */
// Response checker for the bus controller testbench: compares read data, ROM port
// outputs, Z80 control outputs and reset values, and counts mismatches

module md_bus_checker (
	input  logic        MCLK,
	input  logic        reset,
	input  logic        cur_port,
	input  logic        cur_rnw,
	input  logic [15:0] cur_expect,
	input  logic        cur_chk_ctrl,
	input  logic        exp_busreq_n,
	input  logic        exp_reset_n,
	input  logic        cur_chk_rom,
	input  logic [23:0] cur_rom_word,
	input  logic [1:0]  cur_lanes,
	input  logic [15:0] cur_wdata,
	input  logic        m68k_dtack,
	input  logic [15:0] m68k_rdata,
	input  logic        z80_ack,
	input  logic [7:0]  z80_rdata,
	input  logic        rom_req,
	input  logic [23:0] rom_addr,
	input  logic [1:0]  rom_be,
	input  logic [15:0] rom_wdata,
	input  logic        z80_busreq_n,
	input  logic        z80_reset_n,
	output int          error_count,
	output int          check_count
);

	timeunit 1ns;
	timeprecision 100ps;

	logic reset_q;
	logic dtack_q;
	logic ack_q;
	logic req_q;

	initial begin
		error_count = 0;
		check_count = 0;
		reset_q     = 1'b1;
		dtack_q     = 1'b0;
		ack_q       = 1'b0;
		req_q       = 1'b0;
	end

	task automatic compare_bit(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] %0t ns %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic compare_word(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] %0t ns %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_addr(input string name, input logic [23:0] got,
		input logic [23:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] %0t ns %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	// Outputs are registered, so the values seen at the edge are stable
	always @(posedge MCLK) begin
		// First edge after reset release still shows the reset values
		if (reset_q && !reset) begin
			compare_bit("m68k_dtack", m68k_dtack, 1'b0);
			compare_bit("z80_ack", z80_ack, 1'b0);
			compare_bit("rom_req", rom_req, 1'b0);
			compare_bit("z80_busreq_n", z80_busreq_n, 1'b1);
			compare_bit("z80_reset_n", z80_reset_n, 1'b0);
		end

		// A toggle of rom_req starts a ROM access
		if (!reset && rom_req != req_q && cur_chk_rom) begin
			compare_addr("rom_addr", rom_addr, cur_rom_word);
			compare_word("rom_be", {14'b0, rom_be}, {14'b0, cur_lanes});
			compare_word("rom_wdata", rom_wdata, cur_wdata);
		end

		if (!reset && m68k_dtack && !dtack_q && cur_port == 1'b0) begin
			if (cur_rnw) begin
				compare_word("m68k_rdata", m68k_rdata, cur_expect);
			end
			if (cur_chk_ctrl) begin
				compare_bit("z80_busreq_n", z80_busreq_n, exp_busreq_n);
				compare_bit("z80_reset_n", z80_reset_n, exp_reset_n);
			end
		end

		if (!reset && z80_ack && !ack_q && cur_port == 1'b1 && cur_rnw) begin
			compare_word("z80_rdata", {8'h00, z80_rdata}, {8'h00, cur_expect[7:0]});
		end

		reset_q <= reset;
		dtack_q <= m68k_dtack;
		ack_q   <= z80_ack;
		req_q   <= rom_req;
	end

endmodule

/* verification/tb_md_bus.sv */
// Testbench top for the bus controller: clock, reset, ROM model,
// stimulus table and the loop that applies it

module tb_md_bus import md_bus_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT = 200;

	// One table row, port 0 is the 68000 and port 1 the Z80
	typedef struct packed {
		logic        port;
		logic        rnw;
		logic [23:0] addr;
		logic [15:0] wdata;
		logic [1:0]  lanes;
		logic [15:0] expect_val;
		logic        chk_ctrl;
		logic        exp_busreq_n;
		logic        exp_reset_n;
		logic        chk_rom;
		logic [23:0] rom_word;
		// Z80 has granted the bus, z80_busak_n driven low
		logic        busak;
	} test_row_t;

	logic               MCLK;
	logic               reset;
	m68k_req_t          m68k_req;
	logic [MBUS_DW-1:0] m68k_rdata;
	logic               m68k_dtack;
	z80_req_t           z80_req;
	logic [7:0]         z80_rdata;
	logic               z80_ack;
	logic [ROM_AW-1:0]  rom_size;
	logic [ROM_AW-1:0]  rom_addr;
	logic [MBUS_DW-1:0] rom_wdata;
	logic [1:0]         rom_be;
	logic               rom_req;
	logic               rom_ack;
	logic [MBUS_DW-1:0] rom_data;
	logic               z80_busak_n;
	logic               z80_busreq_n;
	logic               z80_reset_n;

	test_row_t rows[$];
	test_row_t cur_row;
	int        error_count;
	int        check_count;
	int        timeout_count;
	int        seed;
	int        rom_wait;
	logic      rom_busy;

	md_bus_top u_md_bus_top (
		.MCLK(MCLK), .reset(reset),
		.m68k_req(m68k_req), .m68k_rdata(m68k_rdata), .m68k_dtack(m68k_dtack),
		.z80_req(z80_req), .z80_rdata(z80_rdata), .z80_ack(z80_ack),
		.rom_size(rom_size), .rom_addr(rom_addr), .rom_wdata(rom_wdata),
		.rom_be(rom_be), .rom_req(rom_req), .rom_ack(rom_ack), .rom_data(rom_data),
		.z80_busak_n(z80_busak_n), .z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n)
	);

	md_bus_checker u_checker (
		.MCLK(MCLK), .reset(reset),
		.cur_port(cur_row.port), .cur_rnw(cur_row.rnw),
		.cur_expect(cur_row.expect_val), .cur_chk_ctrl(cur_row.chk_ctrl),
		.exp_busreq_n(cur_row.exp_busreq_n), .exp_reset_n(cur_row.exp_reset_n),
		.cur_chk_rom(cur_row.chk_rom), .cur_rom_word(cur_row.rom_word),
		.cur_lanes(cur_row.lanes), .cur_wdata(cur_row.wdata),
		.m68k_dtack(m68k_dtack), .m68k_rdata(m68k_rdata),
		.z80_ack(z80_ack), .z80_rdata(z80_rdata), .rom_req(rom_req),
		.rom_addr(rom_addr), .rom_be(rom_be), .rom_wdata(rom_wdata),
		.z80_busreq_n(z80_busreq_n), .z80_reset_n(z80_reset_n),
		.error_count(error_count), .check_count(check_count)
	);

	always #2 MCLK = ~MCLK;

	//------------------------------------------------------------
	// ROM model, answers after 2 to 6 cycles
	//------------------------------------------------------------
	always begin
		@(posedge MCLK);
		#1;
		if (rom_req != rom_ack && !rom_busy) begin
			rom_busy = 1'b1;
			rom_wait = 2 + ($unsigned($random(seed)) % 5);
		end
		if (rom_busy) begin
			rom_wait = rom_wait - 1;
			if (rom_wait <= 0) begin
				rom_data = rom_addr[15:0] ^ 16'hA5A5;
				rom_ack  = rom_req;
				rom_busy = 1'b0;
			end
		end
	end

	task automatic add_row(input logic port, input logic rnw, input logic [23:0] addr,
		input logic [15:0] wdata, input logic [1:0] lanes, input logic [15:0] exp_val);
		test_row_t r;
		r = '0;
		r.port       = port;
		r.rnw        = rnw;
		r.addr       = addr;
		r.wdata      = wdata;
		r.lanes      = lanes;
		r.expect_val = exp_val;
		rows.push_back(r);
	endtask

	// Z80 control write with the expected control outputs afterwards
	task automatic add_ctrl_row(input logic [23:0] addr, input logic [15:0] wdata,
		input logic exp_busreq_n, input logic exp_reset_n);
		test_row_t r;
		r = '0;
		r.addr         = addr;
		r.wdata        = wdata;
		r.lanes        = 2'b10;
		r.chk_ctrl     = 1'b1;
		r.exp_busreq_n = exp_busreq_n;
		r.exp_reset_n  = exp_reset_n;
		rows.push_back(r);
	endtask

	// ROM read with the ROM word address the mapper should produce
	task automatic add_rom_row(input logic [23:0] addr, input logic [23:0] rom_word);
		test_row_t r;
		r = '0;
		r.rnw        = 1'b1;
		r.addr       = addr;
		r.lanes      = 2'b11;
		r.expect_val = rom_word[15:0] ^ 16'hA5A5;
		r.chk_rom    = 1'b1;
		r.rom_word   = rom_word;
		rows.push_back(r);
	endtask

	// Read of A11100 with the Z80 bus acknowledge driven as given
	task automatic add_busak_read(input logic busak, input logic [15:0] exp_val);
		test_row_t r;
		r = '0;
		r.rnw        = 1'b1;
		r.addr       = 24'hA11100;
		r.lanes      = 2'b11;
		r.expect_val = exp_val;
		r.busak      = busak;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// Work RAM, word then byte lanes, and the F00000 mirror
		add_row(0, 0, 24'hE00100, 16'h1234, 2'b11, 16'h0000);
		add_row(0, 1, 24'hE00100, 16'h0000, 2'b11, 16'h1234);
		add_row(0, 0, 24'hE00100, 16'hAB00, 2'b10, 16'h0000);
		add_row(0, 1, 24'hE00100, 16'h0000, 2'b11, 16'hAB34);
		add_row(0, 0, 24'hE00100, 16'h00CD, 2'b01, 16'h0000);
		add_row(0, 1, 24'hF00100, 16'h0000, 2'b11, 16'hABCD);
		// Plain ROM read, word address 00091A
		add_rom_row(24'h001234, 24'h00091A);
		// Bank 9 in mapper slot 1, word 040008 maps to 240008
		add_row(0, 0, 24'hA13003, 16'h0009, 2'b01, 16'h0000);
		add_rom_row(24'h080010, 24'h240008);
		// Save RAM enable, then a byte through the save RAM
		add_row(0, 0, 24'hA13001, 16'h0001, 2'b01, 16'h0000);
		add_row(0, 0, 24'h200000, 16'h005A, 2'b01, 16'h0000);
		add_row(0, 1, 24'h200000, 16'h0000, 2'b11, 16'h5A5A);
		// Z80 window closed while busreq is released
		add_row(0, 1, 24'hA00010, 16'h0000, 2'b11, 16'h0000);
		add_ctrl_row(24'hA11100, 16'h0100, 1'b0, 1'b0);
		add_ctrl_row(24'hA11200, 16'h0100, 1'b0, 1'b1);
		add_row(0, 0, 24'hA00010, 16'h3C00, 2'b10, 16'h0000);
		add_row(0, 1, 24'hA00010, 16'h0000, 2'b11, 16'h3C3C);
		// busak_n shows in bit 8, low once the Z80 grants the bus
		add_busak_read(1'b0, 16'h0100);
		add_busak_read(1'b1, 16'h0000);
		// Z80 port, RAM mirror, unmapped read, shared data
		add_row(1, 0, 24'h000100, 16'h0077, 2'b01, 16'h0000);
		add_row(1, 1, 24'h002100, 16'h0000, 2'b01, 16'h0077);
		add_row(1, 1, 24'h004000, 16'h0000, 2'b01, 16'h00FF);
		add_row(1, 1, 24'h000010, 16'h0000, 2'b01, 16'h003C);
		// Unmapped main-bus reads
		add_row(0, 1, 24'hB00000, 16'h0000, 2'b11, 16'h0000);
		add_row(0, 1, 24'hA14000, 16'h0000, 2'b11, 16'h0000);
	endtask

	task automatic run_m68k_access(input test_row_t r, input int idx);
		int n;
		m68k_req.addr  = r.addr[23:1];
		m68k_req.rnw   = r.rnw;
		m68k_req.uds_n = ~r.lanes[1];
		m68k_req.lds_n = ~r.lanes[0];
		m68k_req.wdata = r.wdata;
		m68k_req.as    = 1'b1;
		n = 0;
		while (!m68k_dtack && n < TIMEOUT) begin
			@(posedge MCLK);
			n++;
		end
		if (!m68k_dtack) begin
			timeout_count++;
			$display("Timeout: no dtack for row %0d at address %h", idx, r.addr);
		end
		#1;
		m68k_req.as = 1'b0;
		n = 0;
		while (m68k_dtack && n < TIMEOUT) begin
			@(posedge MCLK);
			n++;
		end
		if (m68k_dtack) begin
			timeout_count++;
			$display("Timeout: dtack stuck high after row %0d", idx);
		end
	endtask

	task automatic run_z80_access(input test_row_t r, input int idx);
		int n;
		z80_req.addr  = r.addr[15:0];
		z80_req.wr    = ~r.rnw;
		z80_req.wdata = r.wdata[7:0];
		z80_req.sel   = 1'b1;
		n = 0;
		while (!z80_ack && n < TIMEOUT) begin
			@(posedge MCLK);
			n++;
		end
		if (!z80_ack) begin
			timeout_count++;
			$display("Timeout: no Z80 ack for row %0d at address %h", idx, r.addr);
		end
		#1;
		z80_req.sel = 1'b0;
		n = 0;
		while (z80_ack && n < TIMEOUT) begin
			@(posedge MCLK);
			n++;
		end
		if (z80_ack) begin
			timeout_count++;
			$display("Timeout: Z80 ack stuck high after row %0d", idx);
		end
	endtask

	initial begin
		MCLK          = 1'b0;
		reset         = 1'b1;
		m68k_req      = '0;
		z80_req       = '0;
		rom_size      = 24'h200000;
		rom_ack       = 1'b0;
		rom_data      = '0;
		z80_busak_n   = 1'b1;
		cur_row       = '0;
		timeout_count = 0;
		seed          = 21;
		rom_wait      = 0;
		rom_busy      = 1'b0;

		build_table();
		repeat (10) @(posedge MCLK);
		#1;
		reset = 1'b0;
		repeat (2) @(posedge MCLK);

		foreach (rows[i]) begin
			@(posedge MCLK);
			#1;
			cur_row     = rows[i];
			z80_busak_n = ~rows[i].busak;
			if (rows[i].port) begin
				run_z80_access(rows[i], i);
			end else begin
				run_m68k_access(rows[i], i);
			end
		end
		repeat (4) @(posedge MCLK);

		$display("Checks: %0d, mismatches: %0d, timeouts: %0d",
			check_count, error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
